/* Bender.yml */
package:
  name: proc_ctrl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/proc_ctrl_pkg.sv
      - hw/inst_decoder.sv
      - hw/hazard_unit.sv
      - hw/fetch_ctrl.sv
      - hw/decode_ctrl.sv
      - hw/back_end_ctrl.sv
      - hw/proc_ctrl.sv

  - target: simulation
    files:
      - bench/tb_proc_ctrl.sv

/* bench/proc_ctrl_tests.txt */
# test inst_d imemresp_val dmemreq_rdy dmemresp_val mngr2proc_val proc2mngr_rdy br_cond_eq_x
#  | pc_sel imemresp_drop dmemreq_val mngr2proc_rdy proc2mngr_val rf_wen_w rf_waddr_w commit_inst
1 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
1 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
1 00100093 1 1 1 1 1 0 0 0 0 0 0 0 0 0
1 00200113 1 1 1 1 1 0 0 0 0 0 0 0 0 0
1 009403b3 1 1 1 1 1 0 0 0 0 0 0 0 0 0
1 00300193 1 1 1 1 1 0 0 0 0 0 0 1 1 1
1 00000013 1 1 1 1 1 0 0 0 0 0 0 1 2 1
1 00000013 1 1 1 1 1 0 0 0 0 0 0 1 7 1
2 00400213 1 1 1 1 1 0 0 0 0 0 0 1 3 1
2 001202b3 1 1 1 1 1 0 0 0 0 0 0 0 0 1
2 001202b3 1 1 1 1 1 0 0 0 0 0 0 0 0 1
2 001202b3 1 1 1 1 1 0 0 0 0 0 0 1 4 1
2 001202b3 1 1 1 1 1 0 0 0 0 0 0 0 0 0
2 00500013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
2 00000333 1 1 1 1 1 0 0 0 0 0 0 0 0 0
3 00209063 1 1 1 1 1 0 0 0 0 0 0 1 5 1
3 00900493 1 1 1 1 1 0 1 1 0 0 0 1 0 1
3 00a00513 1 1 1 1 1 0 0 0 0 0 0 1 6 1
3 00209063 1 1 1 1 1 0 0 0 0 0 0 0 0 1
3 00b00593 1 1 1 1 1 1 0 0 0 0 0 0 0 0
3 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
4 00002603 1 1 1 1 1 0 0 0 0 0 0 0 0 1
4 00d00693 1 0 1 1 1 0 0 0 0 0 0 1 11 1
4 00d00693 1 0 1 1 1 0 0 0 0 0 0 0 0 1
4 00d00693 1 1 1 1 1 0 0 0 1 0 0 0 0 0
4 00000013 1 1 0 1 1 0 0 0 0 0 0 0 0 0
4 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
5 fc002773 1 1 1 0 1 0 0 0 0 0 0 1 12 1
5 fc002773 1 1 1 0 1 0 0 0 0 0 0 1 13 1
5 fc002773 1 1 1 1 1 0 0 0 0 1 0 0 0 1
5 7c009073 1 1 1 1 1 0 0 0 0 0 0 0 0 0
5 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
5 00000013 1 1 1 1 1 0 0 0 0 0 0 1 14 1
5 00000013 1 1 1 1 0 0 0 0 0 0 0 0 0 0
5 00000013 1 1 1 1 0 0 0 0 0 0 0 0 0 0
5 00000013 1 1 1 1 1 0 0 0 0 0 1 0 0 1
6 ffffffff 1 1 1 1 1 0 0 0 0 0 0 0 0 1
6 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 1
6 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 1
6 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 0
6 00000013 1 1 1 1 1 0 0 0 0 0 0 0 0 1

/* bench/tb_proc_ctrl.sv */
//--------------------------------------------------------------------------
// Pipeline control unit testbench with vector file reader, stimulus,
// output checks against the expected columns and per-test report
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_proc_ctrl;

  localparam int PERIOD   = 40;
  localparam int MAX_VECS = 256;

  logic                      clk;
  logic                      reset;
  logic                      imemreq_val;
  logic                      imemreq_rdy;
  logic                      imemresp_val;
  logic                      imemresp_rdy;
  logic                      imemresp_drop;
  logic                      dmemreq_val;
  logic                      dmemreq_rdy;
  logic                      dmemresp_val;
  logic                      dmemresp_rdy;
  logic                      mngr2proc_val;
  logic                      mngr2proc_rdy;
  logic                      proc2mngr_val;
  logic                      proc2mngr_rdy;
  proc_ctrl_pkg::inst_word_u inst_d;
  logic                      br_cond_eq_x;
  proc_ctrl_pkg::dpath_f_t   ctrl_f;
  proc_ctrl_pkg::dpath_d_t   ctrl_d;
  proc_ctrl_pkg::dpath_xmw_t ctrl_xmw;
  logic                      commit_inst;

  // One vector entry per cycle
  int          vec_test   [MAX_VECS];
  logic [31:0] vec_inst   [MAX_VECS];
  logic [5:0]  vec_in     [MAX_VECS];
  logic [1:0]  vec_pc_sel [MAX_VECS];
  logic [5:0]  vec_exp    [MAX_VECS];
  logic [4:0]  vec_waddr  [MAX_VECS];
  int          num_vecs;
  bit          loaded;

  int errors;
  int checks;
  int test_errors;
  int test_cycles;
  int cycle_count;
  int cycle_limit;

  proc_ctrl UUT (
    .clk           (clk),
    .reset         (reset),
    .imemreq_val   (imemreq_val),
    .imemreq_rdy   (imemreq_rdy),
    .imemresp_val  (imemresp_val),
    .imemresp_rdy  (imemresp_rdy),
    .imemresp_drop (imemresp_drop),
    .dmemreq_val   (dmemreq_val),
    .dmemreq_rdy   (dmemreq_rdy),
    .dmemresp_val  (dmemresp_val),
    .dmemresp_rdy  (dmemresp_rdy),
    .mngr2proc_val (mngr2proc_val),
    .mngr2proc_rdy (mngr2proc_rdy),
    .proc2mngr_val (proc2mngr_val),
    .proc2mngr_rdy (proc2mngr_rdy),
    .inst_d        (inst_d),
    .br_cond_eq_x  (br_cond_eq_x),
    .ctrl_f        (ctrl_f),
    .ctrl_d        (ctrl_d),
    .ctrl_xmw      (ctrl_xmw),
    .commit_inst   (commit_inst)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  //------------------------------------------------------------------------
  // Vector file reader
  //------------------------------------------------------------------------
  task automatic load_vectors();
    int    fd;
    int    n;
    int    t;
    string line;
    logic [31:0] inst;
    logic  i0, i1, i2, i3, i4, i5;
    int    pc;
    logic  e0, e1, e2, e3, e4, e5;
    int    wa;
    num_vecs = 0;
    fd = $fopen("bench/proc_ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file bench/proc_ctrl_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && num_vecs < MAX_VECS) begin
        n = $fgets(line, fd);
        // Skip empty lines and column notes
        if (n > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%d %h %b %b %b %b %b %b %d %b %b %b %b %b %d %b",
                      t, inst, i0, i1, i2, i3, i4, i5,
                      pc, e0, e1, e2, e3, e4, wa, e5);
          if (n == 16) begin
            vec_test[num_vecs]   = t;
            vec_inst[num_vecs]   = inst;
            vec_in[num_vecs]     = {i0, i1, i2, i3, i4, i5};
            vec_pc_sel[num_vecs] = pc[1:0];
            vec_exp[num_vecs]    = {e0, e1, e2, e3, e4, e5};
            vec_waddr[num_vecs]  = wa[4:0];
            num_vecs++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One compare that reports a mismatch at once
  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // Handshake outputs and write enables stay low while reset is high
  task automatic check_reset_outputs();
    compare_value("imemreq_val", 1'b0, imemreq_val);
    compare_value("dmemreq_val", 1'b0, dmemreq_val);
    compare_value("dmemresp_rdy", 1'b0, dmemresp_rdy);
    compare_value("mngr2proc_rdy", 1'b0, mngr2proc_rdy);
    compare_value("proc2mngr_val", 1'b0, proc2mngr_val);
    compare_value("rf_wen_w", 1'b0, ctrl_xmw.rf_wen_w);
    compare_value("commit_inst", 1'b0, commit_inst);
  endtask

  // Expected bit group holds drop, dmemreq, mngr2proc_rdy,
  // proc2mngr_val, rf_wen_w and commit from the top bit down
  task automatic check_outputs(input int i);
    compare_value("ctrl_f.pc_sel", vec_pc_sel[i], ctrl_f.pc_sel);
    compare_value("imemresp_drop", vec_exp[i][5], imemresp_drop);
    compare_value("dmemreq_val", vec_exp[i][4], dmemreq_val);
    compare_value("mngr2proc_rdy", vec_exp[i][3], mngr2proc_rdy);
    compare_value("proc2mngr_val", vec_exp[i][2], proc2mngr_val);
    compare_value("rf_wen_w", vec_exp[i][1], ctrl_xmw.rf_wen_w);
    // Write address only matters with the write enable up
    if (vec_exp[i][1]) begin
      compare_value("rf_waddr_w", vec_waddr[i], ctrl_xmw.rf_waddr_w);
    end
    compare_value("commit_inst", vec_exp[i][0], commit_inst);
    // A load waiting in M never accepts a missing response
    if (!vec_in[i][3]) begin
      compare_value("dmemresp_rdy", 1'b0, dmemresp_rdy);
    end
  endtask

  task automatic drive_inputs(input int i);
    inst_d        = vec_inst[i];
    imemresp_val  = vec_in[i][5];
    dmemreq_rdy   = vec_in[i][4];
    dmemresp_val  = vec_in[i][3];
    mngr2proc_val = vec_in[i][2];
    proc2mngr_rdy = vec_in[i][1];
    br_cond_eq_x  = vec_in[i][0];
  endtask

  //------------------------------------------------------------------------
  // Stimulus and report
  //------------------------------------------------------------------------
  initial begin
    reset         = 1'b1;
    imemreq_rdy   = 1'b1;
    imemresp_val  = 1'b0;
    dmemreq_rdy   = 1'b1;
    dmemresp_val  = 1'b0;
    mngr2proc_val = 1'b0;
    proc2mngr_rdy = 1'b1;
    inst_d        = 32'h0000_0013;
    br_cond_eq_x  = 1'b0;
    errors        = 0;
    checks        = 0;
    test_errors   = 0;
    test_cycles   = 0;
    loaded        = 1'b0;

    load_vectors();
    cycle_limit = 2 * num_vecs + 20;
    loaded = 1'b1;

    // Reset held for 3 rising edges, checked once the first edge has
    // cleared the valid bits
    @(posedge clk);
    repeat (2) begin
      @(negedge clk);
      #(PERIOD / 2 - 1);
      check_reset_outputs();
      @(posedge clk);
    end
    $display("reset: %0d errors", test_errors);
    test_errors = 0;

    for (int i = 0; i < num_vecs; i++) begin
      @(negedge clk);
      if (i == 0) reset = 1'b0;
      drive_inputs(i);
      // Sample just before the next rising edge
      #(PERIOD / 2 - 1);
      check_outputs(i);
      // First fetch goes out right after reset, no response port opens yet
      if (i == 0) begin
        compare_value("imemreq_val", 1'b1, imemreq_val);
        compare_value("dmemresp_rdy", 1'b0, dmemresp_rdy);
      end
      test_cycles++;
      if (i == num_vecs - 1 || vec_test[i + 1] != vec_test[i]) begin
        $display("test %0d: %0d cycles, %0d errors", vec_test[i], test_cycles,
                 test_errors);
        test_cycles = 0;
        test_errors = 0;
      end
    end

    $display("vectors %0d, checks %0d, errors %0d", num_vecs, checks, errors);
    if (errors == 0 && num_vecs > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Guard against a stuck run
  initial begin
    cycle_count = 0;
    wait (loaded);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles", cycle_count);
    $display("Errors found");
    $finish;
  end

endmodule

/* hw/back_end_ctrl.sv */
//--------------------------------------------------------------------------
// X, M and W pipeline registers, branch resolution, data memory and
// proc2mngr handshakes, writeback and commit
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module back_end_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      next_val_d,
  input  proc_ctrl_pkg::decode_t    dec_d,
  input  logic                      br_cond_eq_x,
  input  logic                      dmemreq_rdy,
  input  logic                      dmemresp_val,
  input  logic                      proc2mngr_rdy,
  output logic                      back_stall,
  output logic                      osquash_x,
  output logic                      pc_redirect,
  output proc_ctrl_pkg::dest_t      dest_x,
  output proc_ctrl_pkg::dest_t      dest_m,
  output proc_ctrl_pkg::dest_t      dest_w,
  output logic                      dmemreq_val,
  output logic                      dmemresp_rdy,
  output logic                      proc2mngr_val,
  output proc_ctrl_pkg::dpath_xmw_t ctrl_xmw,
  output logic                      commit_inst
);

  logic                   val_x;
  logic                   val_m;
  logic                   val_w;
  proc_ctrl_pkg::decode_t dec_x;
  proc_ctrl_pkg::decode_t dec_m;
  proc_ctrl_pkg::decode_t dec_w;
  logic                   mem_x;
  logic                   mem_m;
  logic                   ostall_x;
  logic                   ostall_m;
  logic                   ostall_w;
  logic                   stall_x;
  logic                   stall_m;
  logic                   stall_w;
  logic                   next_val_x;
  logic                   next_val_m;
  logic                   rf_wen_w;

  //------------------------------------------------------------------------
  // Stall chain where each stage also waits on everything ahead of it
  //------------------------------------------------------------------------
  assign mem_x    = dec_x.mem_req != proc_ctrl_pkg::mem_none;
  assign mem_m    = dec_m.mem_req != proc_ctrl_pkg::mem_none;
  assign ostall_x = val_x && mem_x && !dmemreq_rdy;
  assign ostall_m = val_m && mem_m && !dmemresp_val;
  assign ostall_w = val_w && dec_w.proc2mngr_req && !proc2mngr_rdy;

  assign stall_w    = ostall_w;
  assign stall_m    = val_m && (ostall_m || ostall_w);
  assign stall_x    = val_x && (ostall_x || ostall_m || ostall_w);
  assign back_stall = ostall_x || ostall_m || ostall_w;

  // A stalled stage hands a bubble forward
  assign next_val_x = val_x && !stall_x;
  assign next_val_m = val_m && !stall_m;

  //------------------------------------------------------------------------
  // Pipeline registers
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      if (!stall_x) val_x <= next_val_d;
      if (!stall_m) val_m <= next_val_x;
      if (!stall_w) val_w <= next_val_m;
    end
  end

  // Decoded payload is only meaningful under the valid bits
  always_ff @(posedge clk) begin
    if (!stall_x) dec_x <= dec_d;
    if (!stall_m) dec_m <= dec_x;
    if (!stall_w) dec_w <= dec_m;
  end

  //------------------------------------------------------------------------
  // X stage bne resolution and data memory request
  //------------------------------------------------------------------------
  assign pc_redirect = val_x && (dec_x.br_type == proc_ctrl_pkg::br_bne) && !br_cond_eq_x;
  // Squash once only, not again while X is held
  assign osquash_x   = pc_redirect && !stall_x;
  assign dmemreq_val = val_x && !stall_x && mem_x;

  // M and W handshakes, write enable and commit
  assign dmemresp_rdy  = val_m && !stall_m && mem_m;
  assign proc2mngr_val = val_w && !stall_w && dec_w.proc2mngr_req;
  assign rf_wen_w      = val_w && dec_w.rf_wen_pending;
  assign commit_inst   = val_w && !stall_w;

  // Destinations seen by the hazard check in D
  assign dest_x = '{val: val_x, rf_wen_pending: dec_x.rf_wen_pending, waddr: dec_x.rf_waddr};
  assign dest_m = '{val: val_m, rf_wen_pending: dec_m.rf_wen_pending, waddr: dec_m.rf_waddr};
  assign dest_w = '{val: val_w, rf_wen_pending: dec_w.rf_wen_pending, waddr: dec_w.rf_waddr};

  assign ctrl_xmw = '{reg_en_x: !stall_x, alu_fn_x: dec_x.alu_fn,
                      reg_en_m: !stall_m, wb_sel_m: dec_m.wb_sel,
                      reg_en_w: !stall_w, rf_waddr_w: dec_w.rf_waddr,
                      rf_wen_w: rf_wen_w};

  // An issued load has nothing stalling X, so it reaches M next cycle
  a_dmemreq_moves: assert property (@(posedge clk) disable iff (reset)
    dmemreq_val |-> !stall_x ##1 val_m);

  // A proc2mngr write commits only together with the manager taking it
  a_commit_valid: assert property (@(posedge clk) disable iff (reset)
    commit_inst |-> val_w && (!dec_w.proc2mngr_req || proc2mngr_rdy));

endmodule

/* hw/decode_ctrl.sv */
//--------------------------------------------------------------------------
// D-stage valid bit, D stall and mngr2proc handshake
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "proc_ctrl_macros.svh"

module decode_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       next_val_f,
  input  proc_ctrl_pkg::inst_word_u  inst_d,
  input  logic                       back_stall,
  input  logic                       osquash_x,
  input  proc_ctrl_pkg::dest_t       dest_x,
  input  proc_ctrl_pkg::dest_t       dest_m,
  input  proc_ctrl_pkg::dest_t       dest_w,
  input  logic                       mngr2proc_val,
  output logic                       front_stall,
  output logic                       mngr2proc_rdy,
  output logic                       next_val_d,
  output proc_ctrl_pkg::decode_t     dec_d,
  output proc_ctrl_pkg::dpath_d_t    ctrl_d
);

  logic [`PROC_REG_AW-1:0] rs1;
  logic [`PROC_REG_AW-1:0] rs2;
  logic                    raw_stall;
  logic                    val_d;
  logic                    ostall_mngr_d;
  logic                    ostall_d;
  logic                    stall_d;
  logic                    squash_d;
  logic                    reg_en_d;

  inst_decoder u_inst_decoder (
    .inst (inst_d),
    .dec  (dec_d),
    .rs1  (rs1),
    .rs2  (rs2)
  );

  hazard_unit u_hazard_unit (
    .rs1       (rs1),
    .rs2       (rs2),
    .rs1_en    (dec_d.rs1_en),
    .rs2_en    (dec_d.rs2_en),
    .dest_x    (dest_x),
    .dest_m    (dest_m),
    .dest_w    (dest_w),
    .raw_stall (raw_stall)
  );

  assign reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d) begin
      val_d <= next_val_f;
    end
  end

  // csrr waits here for manager data
  assign ostall_mngr_d = dec_d.mngr2proc_req && !mngr2proc_val;
  assign ostall_d      = val_d && (raw_stall || ostall_mngr_d);
  assign stall_d       = val_d && (ostall_d || back_stall);
  assign squash_d      = val_d && osquash_x;
  assign front_stall   = ostall_d || back_stall;

  // Take manager data only when the csrr really leaves D
  assign mngr2proc_rdy = val_d && !stall_d && !squash_d && dec_d.mngr2proc_req;

  // Undecoded words leave D as a bubble
  assign next_val_d = val_d && !stall_d && !squash_d && dec_d.inst_val;

  assign ctrl_d = '{reg_en: reg_en_d, op2_sel: dec_d.op2_sel, imm_type: dec_d.imm_type};

  // No stall cause may be active while manager data is taken
  a_mngr_no_stall: assert property (@(posedge clk) disable iff (reset)
    mngr2proc_rdy |-> mngr2proc_val && !raw_stall && !back_stall);

endmodule

/* hw/fetch_ctrl.sv */
//--------------------------------------------------------------------------
// F-stage valid bit, PC select and instruction memory handshake
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    front_stall,
  input  logic                    osquash_x,
  input  logic                    pc_redirect,
  input  logic                    imemresp_val,
  output logic                    imemreq_val,
  output logic                    imemresp_rdy,
  output logic                    imemresp_drop,
  output logic                    next_val_f,
  output proc_ctrl_pkg::dpath_f_t ctrl_f
);

  logic val_f;
  logic ostall_f;
  logic stall_f;
  logic squash_f;
  logic reg_en_f;

  // A squash overrides a stall so the redirected fetch can go out
  assign reg_en_f = !stall_f || squash_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (reg_en_f) begin
      val_f <= 1'b1;
    end
  end

  assign ostall_f = val_f && !imemresp_val;
  assign stall_f  = val_f && (ostall_f || front_stall);
  assign squash_f = val_f && osquash_x;

  // Request goes out ahead of F and never while reset is high
  assign imemreq_val   = reg_en_f && !reset;
  assign imemresp_rdy  = reg_en_f;
  assign imemresp_drop = squash_f;

  assign next_val_f = val_f && !stall_f && !squash_f;

  // pc_sel 1 is the branch target, 0 is pc + 4
  assign ctrl_f = '{reg_en: reg_en_f, pc_sel: pc_redirect ? 2'd1 : 2'd0};

  // A dropped response always goes with a redirect to the branch target
  a_drop_valid: assert property (@(posedge clk) disable iff (reset)
    imemresp_drop |-> val_f && pc_redirect);

endmodule

/* hw/hazard_unit.sv */
//--------------------------------------------------------------------------
// RAW hazard check of D sources against X, M and W destinations
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "proc_ctrl_macros.svh"

module hazard_unit (
  input  logic [`PROC_REG_AW-1:0] rs1,
  input  logic [`PROC_REG_AW-1:0] rs2,
  input  logic                    rs1_en,
  input  logic                    rs2_en,
  input  proc_ctrl_pkg::dest_t    dest_x,
  input  proc_ctrl_pkg::dest_t    dest_m,
  input  proc_ctrl_pkg::dest_t    dest_w,
  output logic                    raw_stall
);

  logic [5:0] hits;

  // One source against one stage, x0 is never a real dependence
  function automatic logic raw_hit(
    input logic [`PROC_REG_AW-1:0] src,
    input logic                    en,
    input proc_ctrl_pkg::dest_t    dest
  );
    raw_hit = en && dest.val && dest.rf_wen_pending
              && (src == dest.waddr) && (dest.waddr != '0);
  endfunction

  // No bypass paths, so a hit holds D until the writer leaves W
  assign hits = {raw_hit(rs1, rs1_en, dest_x),
                 raw_hit(rs1, rs1_en, dest_m),
                 raw_hit(rs1, rs1_en, dest_w),
                 raw_hit(rs2, rs2_en, dest_x),
                 raw_hit(rs2, rs2_en, dest_m),
                 raw_hit(rs2, rs2_en, dest_w)};

  assign raw_stall = |hits;

  // Register zero never causes a stall
  a_no_x0_stall: assert final (!raw_stall || (rs1_en && rs1 != '0) || (rs2_en && rs2 != '0));

endmodule

/* hw/inst_decoder.sv */
//--------------------------------------------------------------------------
// D-stage decode table and manager CSR decode
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "proc_ctrl_macros.svh"

module inst_decoder (
  input  proc_ctrl_pkg::inst_word_u inst,
  output proc_ctrl_pkg::decode_t    dec,
  output logic [`PROC_REG_AW-1:0]   rs1,
  output logic [`PROC_REG_AW-1:0]   rs2
);

  logic [`PROC_XLEN-1:0]  word;
  logic [`PROC_CSR_W-1:0] csr;
  logic                   is_csrr;
  logic                   is_csrw;

  // Raw word for the match table, fields from the two views
  assign word = inst;
  assign rs1  = inst.r_view.rs1;
  assign rs2  = inst.r_view.rs2;
  assign csr  = inst.i_view.csr_imm;

  always_comb begin
    // Start as a register-register op, each row patches what differs
    dec                = '0;
    dec.inst_val       = 1'b1;
    dec.rs1_en         = 1'b1;
    dec.rs2_en         = 1'b1;
    dec.op2_sel        = proc_ctrl_pkg::op2_rf;
    dec.alu_fn         = proc_ctrl_pkg::alu_add;
    dec.rf_wen_pending = 1'b1;
    dec.rf_waddr       = inst.r_view.rd;
    is_csrr            = 1'b0;
    is_csrw            = 1'b0;
    casez (word)
      `PROC_INST_NOP: begin
        dec.rs1_en         = 1'b0;
        dec.rs2_en         = 1'b0;
        dec.rf_wen_pending = 1'b0;
      end
      // Register-register arithmetic, logic and shifts
      `PROC_INST_ADD:  dec.alu_fn = proc_ctrl_pkg::alu_add;
      `PROC_INST_SUB:  dec.alu_fn = proc_ctrl_pkg::alu_sub;
      `PROC_INST_AND:  dec.alu_fn = proc_ctrl_pkg::alu_and;
      `PROC_INST_OR:   dec.alu_fn = proc_ctrl_pkg::alu_or;
      `PROC_INST_XOR:  dec.alu_fn = proc_ctrl_pkg::alu_xor;
      `PROC_INST_SLT:  dec.alu_fn = proc_ctrl_pkg::alu_slt;
      `PROC_INST_SLTU: dec.alu_fn = proc_ctrl_pkg::alu_sltu;
      `PROC_INST_SRA:  dec.alu_fn = proc_ctrl_pkg::alu_sra;
      `PROC_INST_SRL:  dec.alu_fn = proc_ctrl_pkg::alu_srl;
      `PROC_INST_SLL:  dec.alu_fn = proc_ctrl_pkg::alu_sll;
      `PROC_INST_ADDI: begin
        dec.rs2_en   = 1'b0;
        dec.op2_sel  = proc_ctrl_pkg::op2_imm;
        dec.imm_type = proc_ctrl_pkg::imm_i;
      end
      // Address is rs1 + imm, result comes from the memory response
      `PROC_INST_LW: begin
        dec.rs2_en   = 1'b0;
        dec.op2_sel  = proc_ctrl_pkg::op2_imm;
        dec.imm_type = proc_ctrl_pkg::imm_i;
        dec.mem_req  = proc_ctrl_pkg::mem_load;
        dec.wb_sel   = proc_ctrl_pkg::wb_mem;
      end
      `PROC_INST_BNE: begin
        dec.br_type        = proc_ctrl_pkg::br_bne;
        dec.imm_type       = proc_ctrl_pkg::imm_b;
        dec.rf_wen_pending = 1'b0;
      end
      // csrr takes manager data on operand 2
      `PROC_INST_CSRR: begin
        dec.rs1_en  = 1'b0;
        dec.rs2_en  = 1'b0;
        dec.op2_sel = proc_ctrl_pkg::op2_mngr;
        dec.alu_fn  = proc_ctrl_pkg::alu_cp1;
        is_csrr     = 1'b1;
      end
      `PROC_INST_CSRW: begin
        dec.rs2_en         = 1'b0;
        dec.alu_fn         = proc_ctrl_pkg::alu_cp0;
        dec.rf_wen_pending = 1'b0;
        is_csrw            = 1'b1;
      end
      default: dec = '0;
    endcase
    // Only the two manager CSRs are known
    dec.proc2mngr_req = is_csrw && (csr == `PROC_CSR_PROC2MNGR);
    dec.mngr2proc_req = is_csrr && (csr == `PROC_CSR_MNGR2PROC);
  end

endmodule

/* hw/proc_ctrl.sv */
//--------------------------------------------------------------------------
// Pipeline control top, joins the F, D and back-end controllers
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module proc_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  // Instruction memory
  output logic                      imemreq_val,
  input  logic                      imemreq_rdy,
  input  logic                      imemresp_val,
  output logic                      imemresp_rdy,
  output logic                      imemresp_drop,
  // Data memory
  output logic                      dmemreq_val,
  input  logic                      dmemreq_rdy,
  input  logic                      dmemresp_val,
  output logic                      dmemresp_rdy,
  // Manager ports
  input  logic                      mngr2proc_val,
  output logic                      mngr2proc_rdy,
  output logic                      proc2mngr_val,
  input  logic                      proc2mngr_rdy,
  // Datapath status and control
  input  proc_ctrl_pkg::inst_word_u inst_d,
  input  logic                      br_cond_eq_x,
  output proc_ctrl_pkg::dpath_f_t   ctrl_f,
  output proc_ctrl_pkg::dpath_d_t   ctrl_d,
  output proc_ctrl_pkg::dpath_xmw_t ctrl_xmw,
  output logic                      commit_inst
);

  // imemreq_rdy is not needed here: a refused fetch shows up as a
  // missing response and stalls F
  logic                   front_stall;
  logic                   back_stall;
  logic                   osquash_x;
  logic                   pc_redirect;
  logic                   next_val_f;
  logic                   next_val_d;
  proc_ctrl_pkg::decode_t dec_d;
  proc_ctrl_pkg::dest_t   dest_x;
  proc_ctrl_pkg::dest_t   dest_m;
  proc_ctrl_pkg::dest_t   dest_w;

  fetch_ctrl u_fetch_ctrl (
    .clk (clk), .reset (reset), .front_stall (front_stall), .osquash_x (osquash_x),
    .pc_redirect (pc_redirect), .imemresp_val (imemresp_val), .imemreq_val (imemreq_val),
    .imemresp_rdy (imemresp_rdy), .imemresp_drop (imemresp_drop),
    .next_val_f (next_val_f), .ctrl_f (ctrl_f)
  );

  decode_ctrl u_decode_ctrl (
    .clk (clk), .reset (reset), .next_val_f (next_val_f), .inst_d (inst_d),
    .back_stall (back_stall), .osquash_x (osquash_x), .dest_x (dest_x),
    .dest_m (dest_m), .dest_w (dest_w), .mngr2proc_val (mngr2proc_val),
    .front_stall (front_stall), .mngr2proc_rdy (mngr2proc_rdy),
    .next_val_d (next_val_d), .dec_d (dec_d), .ctrl_d (ctrl_d)
  );

  back_end_ctrl u_back_end_ctrl (
    .clk (clk), .reset (reset), .next_val_d (next_val_d), .dec_d (dec_d),
    .br_cond_eq_x (br_cond_eq_x), .dmemreq_rdy (dmemreq_rdy),
    .dmemresp_val (dmemresp_val), .proc2mngr_rdy (proc2mngr_rdy),
    .back_stall (back_stall), .osquash_x (osquash_x), .pc_redirect (pc_redirect),
    .dest_x (dest_x), .dest_m (dest_m), .dest_w (dest_w), .dmemreq_val (dmemreq_val),
    .dmemresp_rdy (dmemresp_rdy), .proc2mngr_val (proc2mngr_val),
    .ctrl_xmw (ctrl_xmw), .commit_inst (commit_inst)
  );

endmodule

/* hw/proc_ctrl_macros.svh */
//--------------------------------------------------------------------------
// Widths, manager CSR numbers and casez match patterns for the
// instruction subset handled by the control unit
//--------------------------------------------------------------------------
`ifndef PROC_CTRL_MACROS_SVH
`define PROC_CTRL_MACROS_SVH

`define PROC_XLEN   32
`define PROC_REG_AW 5
`define PROC_CSR_W  12

// Manager CSR numbers
`define PROC_CSR_PROC2MNGR 12'h7c0
`define PROC_CSR_MNGR2PROC 12'hfc0

// Match patterns; nop is addi x0, x0, 0 and must be tried before addi
`define PROC_INST_NOP  32'b0000000_00000_00000_000_00000_0010011
`define PROC_INST_ADD  32'b0000000_?????_?????_000_?????_0110011
`define PROC_INST_SUB  32'b0100000_?????_?????_000_?????_0110011
`define PROC_INST_AND  32'b0000000_?????_?????_111_?????_0110011
`define PROC_INST_OR   32'b0000000_?????_?????_110_?????_0110011
`define PROC_INST_XOR  32'b0000000_?????_?????_100_?????_0110011
`define PROC_INST_SLT  32'b0000000_?????_?????_010_?????_0110011
`define PROC_INST_SLTU 32'b0000000_?????_?????_011_?????_0110011
`define PROC_INST_SRA  32'b0100000_?????_?????_101_?????_0110011
`define PROC_INST_SRL  32'b0000000_?????_?????_101_?????_0110011
`define PROC_INST_SLL  32'b0000000_?????_?????_001_?????_0110011
`define PROC_INST_ADDI 32'b????????????_?????_000_?????_0010011
`define PROC_INST_LW   32'b????????????_?????_010_?????_0000011
`define PROC_INST_BNE  32'b???????_?????_?????_001_?????_1100011
`define PROC_INST_CSRR 32'b????????????_00000_010_?????_1110011
`define PROC_INST_CSRW 32'b????????????_?????_001_00000_1110011

`endif

/* hw/proc_ctrl_pkg.sv */
//--------------------------------------------------------------------------
// Instruction word views, decode enums and control word structs
//--------------------------------------------------------------------------
`include "proc_ctrl_macros.svh"

package proc_ctrl_pkg;

  // One instruction word, read as R-type or as I-type with a CSR number
  typedef union packed {
    struct packed {
      logic [6:0]              funct7;
      logic [`PROC_REG_AW-1:0] rs2;
      logic [`PROC_REG_AW-1:0] rs1;
      logic [2:0]              funct3;
      logic [`PROC_REG_AW-1:0] rd;
      logic [6:0]              opcode;
    } r_view;
    struct packed {
      logic [`PROC_CSR_W-1:0]  csr_imm;
      logic [`PROC_REG_AW-1:0] rs1;
      logic [2:0]              funct3;
      logic [`PROC_REG_AW-1:0] rd;
      logic [6:0]              opcode;
    } i_view;
  } inst_word_u;

  typedef enum logic [0:0] { br_none = 1'b0, br_bne = 1'b1 } br_type_e;

  // Operand 2 mux in D
  typedef enum logic [1:0] { op2_rf = 2'd0, op2_imm = 2'd1, op2_mngr = 2'd2 } op2_sel_e;

  typedef enum logic [2:0] {
    imm_i = 3'd0, imm_s = 3'd1, imm_b = 3'd2, imm_u = 3'd3, imm_j = 3'd4
  } imm_type_e;

  // ALU encodings; cp0 and cp1 pass operand 1 or operand 2 through
  typedef enum logic [3:0] {
    alu_add = 4'd0, alu_sub = 4'd1, alu_and = 4'd2, alu_or = 4'd3,
    alu_xor = 4'd4, alu_slt = 4'd5, alu_sltu = 4'd6, alu_sra = 4'd7,
    alu_srl = 4'd8, alu_sll = 4'd9, alu_cp0 = 4'd11, alu_cp1 = 4'd12
  } alu_fn_e;

  typedef enum logic [1:0] { mem_none = 2'd0, mem_load = 2'd1, mem_store = 2'd2 } mem_req_e;

  // Writeback mux in M
  typedef enum logic [0:0] { wb_alu = 1'b0, wb_mem = 1'b1 } wb_sel_e;

  // Decoded D-stage control, carried down the back end
  typedef struct packed {
    logic                    inst_val;
    br_type_e                br_type;
    imm_type_e               imm_type;
    logic                    rs1_en;
    op2_sel_e                op2_sel;
    logic                    rs2_en;
    alu_fn_e                 alu_fn;
    mem_req_e                mem_req;
    wb_sel_e                 wb_sel;
    logic                    rf_wen_pending;
    logic                    proc2mngr_req;
    logic                    mngr2proc_req;
    logic [`PROC_REG_AW-1:0] rf_waddr;
  } decode_t;

  // Pending destination of one back-end stage
  typedef struct packed {
    logic                    val;
    logic                    rf_wen_pending;
    logic [`PROC_REG_AW-1:0] waddr;
  } dest_t;

  typedef struct packed {
    logic       reg_en;
    logic [1:0] pc_sel;
  } dpath_f_t;

  typedef struct packed {
    logic      reg_en;
    op2_sel_e  op2_sel;
    imm_type_e imm_type;
  } dpath_d_t;

  typedef struct packed {
    logic                    reg_en_x;
    alu_fn_e                 alu_fn_x;
    logic                    reg_en_m;
    wb_sel_e                 wb_sel_m;
    logic                    reg_en_w;
    logic [`PROC_REG_AW-1:0] rf_waddr_w;
    logic                    rf_wen_w;
  } dpath_xmw_t;

endpackage

/* sim.f */
+incdir+hw
hw/proc_ctrl_pkg.sv
hw/inst_decoder.sv
hw/hazard_unit.sv
hw/fetch_ctrl.sv
hw/decode_ctrl.sv
hw/back_end_ctrl.sv
hw/proc_ctrl.sv
bench/tb_proc_ctrl.sv
